// File: design/keypad_pkg.sv
package keypad_pkg;

    // ==============================
    // matrix and code geometry
    // ==============================
    localparam int NUM_ROWS   = 4;
    localparam int NUM_COLS   = 4;
    localparam int ROW_IDX_W  = $clog2(NUM_ROWS);
    localparam int COL_IDX_W  = $clog2(NUM_COLS);
    localparam int KEY_CODE_W = ROW_IDX_W + COL_IDX_W;

    // code FIFO.
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_CNT_W = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // scan timing.
    localparam int SCAN_DIV_W = 8;
    localparam int DEBOUNCE_W = 16;
    localparam logic [SCAN_DIV_W-1:0] SCAN_DIV_RESET = 8'd99;
    localparam logic [DEBOUNCE_W-1:0] DEBOUNCE_RESET = 16'd200;

    // scanner states, column states must stay contiguous.
    localparam int SCAN_ST_W = 3;
    localparam logic [SCAN_ST_W-1:0] ST_IDLE     = 3'd0;
    localparam logic [SCAN_ST_W-1:0] ST_PRESS_DB = 3'd1;
    localparam logic [SCAN_ST_W-1:0] ST_COL0     = 3'd2;
    localparam logic [SCAN_ST_W-1:0] ST_COL1     = 3'd3;
    localparam logic [SCAN_ST_W-1:0] ST_COL2     = 3'd4;
    localparam logic [SCAN_ST_W-1:0] ST_COL3     = 3'd5;
    localparam logic [SCAN_ST_W-1:0] ST_REL_DB   = 3'd6;
    localparam logic [SCAN_ST_W-1:0] ST_HOLD     = 3'd7;

    // ==============================
    // wishbone register map
    // ==============================
    localparam int WB_ADR_W    = 4;
    localparam int WB_DATA_W   = 32;
    localparam int WB_SEL_W    = 4;
    localparam int REG_ADR_LSB = 2;
    localparam int REG_SEL_W   = 2;
    localparam logic [REG_SEL_W-1:0] REG_STATUS = 2'd0;
    localparam logic [REG_SEL_W-1:0] REG_DATA   = 2'd1;
    localparam logic [REG_SEL_W-1:0] REG_CTRL   = 2'd2;
    localparam logic [REG_SEL_W-1:0] REG_TIMING = 2'd3;

    // field positions.
    localparam int STATUS_NE_BIT   = 0;
    localparam int STATUS_OVF_BIT  = 1;
    localparam int STATUS_CNT_LSB  = 4;
    localparam int DATA_CODE_LSB   = 0;
    localparam int DATA_VALID_BIT  = 8;
    localparam int CTRL_EN_BIT     = 0;
    localparam int CTRL_IRQ_EN_BIT = 1;
    localparam int TIMING_DIV_LSB  = 0;
    localparam int TIMING_DEB_LSB  = 8;

endpackage

// File: design/keypad_scanner.sv
module keypad_scanner import keypad_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  scan_en,
    input  logic [SCAN_DIV_W-1:0] scan_div,
    input  logic [DEBOUNCE_W-1:0] debounce_ticks,
    input  logic [NUM_ROWS-1:0]   row,
    output logic [NUM_COLS-1:0]   col,
    output logic [KEY_CODE_W-1:0] key_code,
    output logic                  key_valid
);

    logic [SCAN_DIV_W-1:0] div_cnt;
    logic                  tick;
    logic [NUM_ROWS-1:0]   row_meta;
    logic [NUM_ROWS-1:0]   row_sync;
    logic                  row_active;
    logic [ROW_IDX_W-1:0]  row_idx;
    logic [COL_IDX_W-1:0]  col_idx;
    logic                  col_phase;
    logic [SCAN_ST_W-1:0]  state;
    logic [DEBOUNCE_W-1:0] db_cnt;
    logic [DEBOUNCE_W:0]   db_next;
    logic                  db_done;

    // ==============================
    // tick divider and row sampling
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n || !scan_en || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign tick = scan_en && (div_cnt == scan_div);

    // two-flop synchronizer, so scan_div should be at least 2.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_meta <= '1;
            row_sync <= '1;
        end else begin
            row_meta <= row;
            row_sync <= row_meta;
        end
    end

    assign row_active = ~&row_sync;

    // lowest active row wins.
    always_comb begin
        row_idx = '0;
        for (int i = NUM_ROWS - 1; i >= 0; i--) begin
            if (!row_sync[i]) begin
                row_idx = ROW_IDX_W'(i);
            end
        end
    end

    // ==============================
    // column drive
    // ==============================
    always_comb begin
        col_phase = 1'b1;
        col_idx   = '0;
        case (state)
            ST_COL0: col_idx = COL_IDX_W'(0);
            ST_COL1: col_idx = COL_IDX_W'(1);
            ST_COL2: col_idx = COL_IDX_W'(2);
            ST_COL3: col_idx = COL_IDX_W'(3);
            default: col_phase = 1'b0;
        endcase
    end

    // all columns low outside the scan so any key pulls a row down.
    always_comb begin
        col = '0;
        if (!scan_en) begin
            col = '1;
        end else if (col_phase) begin
            col          = '1;
            col[col_idx] = 1'b0;
        end
    end

    // ==============================
    // scan state machine
    // ==============================
    assign db_next = {1'b0, db_cnt} + 1'b1;
    assign db_done = db_next >= {1'b0, debounce_ticks};

    always_ff @(posedge clk) begin
        if (!rst_n || !scan_en) begin
            state     <= ST_IDLE;
            db_cnt    <= '0;
            key_valid <= 1'b0;
        end else begin
            key_valid <= 1'b0;
            if (tick) begin
                case (state)
                    ST_IDLE: begin
                        db_cnt <= '0;
                        if (row_active) begin
                            state <= ST_PRESS_DB;
                        end
                    end
                    ST_PRESS_DB: begin
                        if (!row_active) begin
                            state <= ST_IDLE;
                        end else if (db_done) begin
                            state  <= ST_COL0;
                            db_cnt <= '0;
                        end else begin
                            db_cnt <= db_next[DEBOUNCE_W-1:0];
                        end
                    end
                    ST_COL0, ST_COL1, ST_COL2, ST_COL3: begin
                        if (row_active) begin
                            state     <= ST_REL_DB;
                            key_valid <= 1'b1;
                        end else if (state == ST_COL3) begin
                            state <= ST_IDLE;
                        end else begin
                            state <= state + 1'b1;
                        end
                    end
                    ST_REL_DB: begin
                        if (row_active) begin
                            state  <= ST_HOLD;
                            db_cnt <= '0;
                        end else if (db_done) begin
                            state <= ST_IDLE;
                        end else begin
                            db_cnt <= db_next[DEBOUNCE_W-1:0];
                        end
                    end
                    ST_HOLD: begin
                        // key still down, wait for the next release.
                        if (!row_active) begin
                            state <= ST_REL_DB;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tick && col_phase && row_active) begin
            key_code <= {row_idx, col_idx};
        end
    end

endmodule

// File: design/key_fifo.sv
module key_fifo import keypad_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  logic [KEY_CODE_W-1:0] push_code,
    input  logic                  pop,
    input  logic                  clear_ovf,
    output logic [KEY_CODE_W-1:0] head_code,
    output logic [FIFO_CNT_W-1:0] fifo_count,
    output logic                  overflow
);

    logic [KEY_CODE_W-1:0] mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic                  full;
    logic                  empty;
    logic                  do_push;
    logic                  do_pop;

    assign full    = fifo_count == FIFO_CNT_W'(FIFO_DEPTH);
    assign empty   = fifo_count == '0;
    assign do_pop  = pop && !empty;
    // a pop frees the slot for a push in the same cycle.
    assign do_push = push && (!full || do_pop);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
            overflow   <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                fifo_count <= fifo_count + 1'b1;
            end else if (do_pop && !do_push) begin
                fifo_count <= fifo_count - 1'b1;
            end
            // a dropped push wins over a clear in the same cycle.
            if (push && !do_push) begin
                overflow <= 1'b1;
            end else if (clear_ovf) begin
                overflow <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_code;
        end
    end

    assign head_code = mem[rd_ptr];

endmodule

// File: design/keypad_regs.sv
module keypad_regs import keypad_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [WB_ADR_W-1:0]   wb_adr,
    input  logic [WB_DATA_W-1:0]  wb_dat_w,
    input  logic [WB_SEL_W-1:0]   wb_sel,
    output logic [WB_DATA_W-1:0]  wb_dat_r,
    output logic                  wb_ack,
    input  logic [KEY_CODE_W-1:0] head_code,
    input  logic [FIFO_CNT_W-1:0] fifo_count,
    input  logic                  overflow,
    output logic                  scan_en,
    output logic [SCAN_DIV_W-1:0] scan_div,
    output logic [DEBOUNCE_W-1:0] debounce_ticks,
    output logic                  pop,
    output logic                  clear_ovf,
    output logic                  irq
);

    logic [REG_SEL_W-1:0] reg_sel;
    logic                 access;
    logic                 wr_access;
    logic                 rd_access;
    logic                 irq_en;
    logic                 not_empty;

    // byte lanes in wb_sel are not decoded, every write is a full word.
    assign reg_sel   = wb_adr[REG_ADR_LSB +: REG_SEL_W];
    assign access    = wb_cyc && wb_stb && wb_ack;
    assign wr_access = access && wb_we;
    assign rd_access = access && !wb_we;
    assign not_empty = fifo_count != '0;

    // ==============================
    // bus handshake
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_cyc && wb_stb && !wb_ack;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_en        <= 1'b0;
            irq_en         <= 1'b0;
            scan_div       <= SCAN_DIV_RESET;
            debounce_ticks <= DEBOUNCE_RESET;
        end else if (wr_access) begin
            case (reg_sel)
                REG_CTRL: begin
                    scan_en <= wb_dat_w[CTRL_EN_BIT];
                    irq_en  <= wb_dat_w[CTRL_IRQ_EN_BIT];
                end
                REG_TIMING: begin
                    scan_div       <= wb_dat_w[TIMING_DIV_LSB +: SCAN_DIV_W];
                    debounce_ticks <= wb_dat_w[TIMING_DEB_LSB +: DEBOUNCE_W];
                end
                default: begin
                end
            endcase
        end
    end

    // pop and clear land on the edge that ends the ack cycle.
    assign pop       = rd_access && (reg_sel == REG_DATA);
    assign clear_ovf = wr_access && (reg_sel == REG_STATUS) && wb_dat_w[STATUS_OVF_BIT];

    always_comb begin
        wb_dat_r = '0;
        case (reg_sel)
            REG_STATUS: begin
                wb_dat_r[STATUS_NE_BIT]                   = not_empty;
                wb_dat_r[STATUS_OVF_BIT]                  = overflow;
                wb_dat_r[STATUS_CNT_LSB +: FIFO_CNT_W]    = fifo_count;
            end
            REG_DATA: begin
                wb_dat_r[DATA_CODE_LSB +: KEY_CODE_W]     = head_code;
                wb_dat_r[DATA_VALID_BIT]                  = not_empty;
            end
            REG_CTRL: begin
                wb_dat_r[CTRL_EN_BIT]                     = scan_en;
                wb_dat_r[CTRL_IRQ_EN_BIT]                 = irq_en;
            end
            default: begin
                wb_dat_r[TIMING_DIV_LSB +: SCAN_DIV_W]    = scan_div;
                wb_dat_r[TIMING_DEB_LSB +: DEBOUNCE_W]    = debounce_ticks;
            end
        endcase
    end

    // level interrupt while codes are waiting.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq <= 1'b0;
        end else begin
            irq <= irq_en && not_empty;
        end
    end

endmodule

// File: design/keypad_ctrl_top.sv
module keypad_ctrl_top import keypad_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [WB_ADR_W-1:0]  wb_adr,
    input  logic [WB_DATA_W-1:0] wb_dat_w,
    input  logic [WB_SEL_W-1:0]  wb_sel,
    output logic [WB_DATA_W-1:0] wb_dat_r,
    output logic                 wb_ack,
    input  logic [NUM_ROWS-1:0]  row,
    output logic [NUM_COLS-1:0]  col,
    output logic                 irq
);

    logic                  scan_en;
    logic [SCAN_DIV_W-1:0] scan_div;
    logic [DEBOUNCE_W-1:0] debounce_ticks;
    logic [KEY_CODE_W-1:0] key_code;
    logic                  key_valid;
    logic                  pop;
    logic                  clear_ovf;
    logic [KEY_CODE_W-1:0] head_code;
    logic [FIFO_CNT_W-1:0] fifo_count;
    logic                  overflow;

    keypad_regs i_keypad_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_sel         (wb_sel),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .head_code      (head_code),
        .fifo_count     (fifo_count),
        .overflow       (overflow),
        .scan_en        (scan_en),
        .scan_div       (scan_div),
        .debounce_ticks (debounce_ticks),
        .pop            (pop),
        .clear_ovf      (clear_ovf),
        .irq            (irq)
    );

    keypad_scanner i_keypad_scanner (
        .clk            (clk),
        .rst_n          (rst_n),
        .scan_en        (scan_en),
        .scan_div       (scan_div),
        .debounce_ticks (debounce_ticks),
        .row            (row),
        .col            (col),
        .key_code       (key_code),
        .key_valid      (key_valid)
    );

    // scanner never stalls, full FIFO drops and flags overflow.
    key_fifo i_key_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (key_valid),
        .push_code  (key_code),
        .pop        (pop),
        .clear_ovf  (clear_ovf),
        .head_code  (head_code),
        .fifo_count (fifo_count),
        .overflow   (overflow)
    );

endmodule

// File: sim/keypad_matrix_model.sv
module keypad_matrix_model import keypad_pkg::*; (
    input  logic [NUM_COLS-1:0]   col,
    input  logic                  pressed,
    input  logic [KEY_CODE_W-1:0] key_idx,
    input  logic                  bounce,
    output logic [NUM_ROWS-1:0]   row
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [ROW_IDX_W-1:0] key_row;
    logic [COL_IDX_W-1:0] key_col;
    logic                 contact;

    // key index is row in the upper bits, column in the lower bits.
    assign key_row = key_idx[COL_IDX_W +: ROW_IDX_W];
    assign key_col = key_idx[COL_IDX_W-1:0];

    // bounce opens the contact while the key is held.
    assign contact = pressed && !bounce;

    // ==============================
    // switch matrix
    // ==============================
    always_comb begin
        // pull-ups keep every row high by default.
        row = '1;
        if (contact && !col[key_col]) begin
            row[key_row] = 1'b0;
        end
    end

endmodule

// File: sim/tb_keypad.sv
module tb_keypad import keypad_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACK_LIMIT   = 16;
    localparam int POLL_LIMIT  = 300;
    localparam int IDLE_CLKS   = 200;
    localparam int SCAN_DIV_TB = 3;
    localparam int DEBOUNCE_TB = 4;
    localparam logic [31:0] TIMING_WORD = (32'(DEBOUNCE_TB) << TIMING_DEB_LSB)
                                        | (32'(SCAN_DIV_TB) << TIMING_DIV_LSB);
    localparam logic [31:0] CNT_MASK = 32'hF << STATUS_CNT_LSB;
    localparam logic [31:0] OVF_MASK = 32'h1 << STATUS_OVF_BIT;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [WB_ADR_W-1:0]   wb_adr;
    logic [WB_DATA_W-1:0]  wb_dat_w;
    logic [WB_SEL_W-1:0]   wb_sel;
    logic [WB_DATA_W-1:0]  wb_dat_r;
    logic                  wb_ack;
    logic [NUM_ROWS-1:0]   row;
    logic [NUM_COLS-1:0]   col;
    logic                  irq;
    logic                  pressed;
    logic [KEY_CODE_W-1:0] key_idx;
    logic                  bounce;
    logic [31:0]           lfsr_state = 32'h78933d28;
    int                    key_order [16];
    int                    expected_q [$];

    always #5 clk = ~clk;

    keypad_ctrl_top i_keypad_ctrl_top (
        .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack), .row(row), .col(col), .irq(irq)
    );

    keypad_matrix_model i_matrix (
        .col(col), .pressed(pressed), .key_idx(key_idx), .bounce(bounce), .row(row)
    );

    // ==============================
    // helpers
    // ==============================
    task automatic fail_run(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            fail_run($sformatf("mismatch %s: expected 0x%0h, actual 0x%0h",
                               name, expected, actual));
        end
    endtask

    // galois form with taps x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int random_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val        = (val << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return val;
    endfunction

    function automatic int expected_code(input int k);
        int r;
        int c;
        r = k / NUM_COLS;
        c = k % NUM_COLS;
        return r * 4 + c;
    endfunction

    function automatic logic [WB_ADR_W-1:0] reg_addr(input logic [REG_SEL_W-1:0] sel);
        return {sel, {REG_ADR_LSB{1'b0}}};
    endfunction

    task automatic shuffle_keys();
        int j;
        int t;
        for (int i = 15; i > 0; i--) begin
            j            = random_bits(4) % (i + 1);
            t            = key_order[i];
            key_order[i] = key_order[j];
            key_order[j] = t;
        end
    endtask

    task automatic wait_ack(input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!wb_ack) begin
            if (waited == ACK_LIMIT) begin
                fail_run($sformatf("timeout waiting for wb_ack on %s", what));
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic wb_write(input logic [REG_SEL_W-1:0] sel, input logic [31:0] data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= reg_addr(sel);
        wb_dat_w <= data;
        wait_ack("write");
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [REG_SEL_W-1:0] sel, output logic [31:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= reg_addr(sel);
        wait_ack("read");
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic wait_status(input logic [31:0] mask, input logic [31:0] value,
                               input string what);
        logic [31:0] data;
        int          polls;
        polls = 0;
        wb_read(REG_STATUS, data);
        while ((data & mask) != value) begin
            if (polls == POLL_LIMIT) begin
                fail_run($sformatf("timeout waiting for STATUS during %s", what));
            end
            polls++;
            wb_read(REG_STATUS, data);
        end
    endtask

    task automatic press_key(input int k);
        @(posedge clk);
        key_idx <= KEY_CODE_W'(k);
        pressed <= 1'b1;
    endtask

    task automatic release_key();
        @(posedge clk);
        pressed <= 1'b0;
        repeat (IDLE_CLKS) @(posedge clk);
    endtask

    task automatic hold_key(input int k, input logic [31:0] mask, input logic [31:0] value,
                            input string what);
        press_key(k);
        wait_status(mask, value, what);
        release_key();
    endtask

    task automatic read_code(input int expected, input string name);
        logic [31:0] data;
        wb_read(REG_DATA, data);
        check_value({name, " valid"}, 1, int'(data[DATA_VALID_BIT]));
        check_value({name, " code"}, expected, int'(data[DATA_CODE_LSB +: KEY_CODE_W]));
    endtask

    // ==============================
    // stimulus
    // ==============================
    initial begin
        logic [31:0] data;
        int          k;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '1;
        pressed  = 1'b0;
        key_idx  = '0;
        bounce   = 1'b0;
        for (int i = 0; i < 16; i++) begin
            key_order[i] = i;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        check_value("reset wb_ack", 0, int'(wb_ack));
        check_value("reset irq", 0, int'(irq));
        check_value("reset col", 'hF, int'(col));
        wb_read(REG_STATUS, data);
        check_value("reset status", 0, int'(data));
        wb_read(REG_TIMING, data);
        check_value("reset scan div", int'(SCAN_DIV_RESET),
                    int'(data[TIMING_DIV_LSB +: SCAN_DIV_W]));
        check_value("reset debounce", int'(DEBOUNCE_RESET),
                    int'(data[TIMING_DEB_LSB +: DEBOUNCE_W]));
        wb_write(REG_TIMING, TIMING_WORD);
        wb_read(REG_TIMING, data);
        check_value("timing readback", int'(TIMING_WORD), int'(data));
        wb_write(REG_CTRL, 32'h3);
        wb_read(REG_CTRL, data);
        check_value("ctrl readback", 3, int'(data));

        // every key once in shuffled order.
        wb_write(REG_CTRL, 32'h1 << CTRL_EN_BIT);
        shuffle_keys();
        for (int i = 0; i < 16; i++) begin
            hold_key(key_order[i], CNT_MASK, 32'h1 << STATUS_CNT_LSB, "code mapping");
            read_code(expected_code(key_order[i]), "mapping");
            wb_read(REG_STATUS, data);
            check_value("mapping not-empty", 0, int'(data[STATUS_NE_BIT]));
        end

        wb_write(REG_CTRL, (32'h1 << CTRL_EN_BIT) | (32'h1 << CTRL_IRQ_EN_BIT));
        shuffle_keys();
        for (int i = 0; i < 3; i++) begin
            hold_key(key_order[i], CNT_MASK, 32'(i + 1) << STATUS_CNT_LSB, "ordering");
            expected_q.push_back(expected_code(key_order[i]));
        end
        wb_read(REG_STATUS, data);
        check_value("ordering count", 3, int'(data[STATUS_CNT_LSB +: FIFO_CNT_W]));
        @(negedge clk);
        check_value("irq enabled", 1, int'(irq));
        wb_write(REG_CTRL, 32'h1 << CTRL_EN_BIT);
        repeat (2) @(negedge clk);
        check_value("irq disabled", 0, int'(irq));
        for (int i = 0; i < 3; i++) begin
            read_code(expected_q.pop_front(), "ordering");
        end
        wb_read(REG_DATA, data);
        check_value("empty pop valid", 0, int'(data[DATA_VALID_BIT]));

        // chattering press with every closure shorter than the debounce window.
        press_key(4);
        for (int i = 0; i < 3; i++) begin
            repeat (2 * (SCAN_DIV_TB + 1)) @(posedge clk);
            bounce <= 1'b1;
            repeat (2 * (SCAN_DIV_TB + 1)) @(posedge clk);
            bounce <= 1'b0;
        end
        repeat (2 * (SCAN_DIV_TB + 1) - 1) @(posedge clk);
        release_key();
        wb_read(REG_STATUS, data);
        check_value("short press status", 0, int'(data));

        for (int i = 0; i < 9; i++) begin
            k = random_bits(4);
            if (i < 8) begin
                hold_key(k, CNT_MASK, 32'(i + 1) << STATUS_CNT_LSB, "overflow fill");
                expected_q.push_back(expected_code(k));
            end else begin
                hold_key(k, OVF_MASK, OVF_MASK, "overflow");
            end
        end
        wb_read(REG_STATUS, data);
        check_value("overflow count", 8, int'(data[STATUS_CNT_LSB +: FIFO_CNT_W]));
        check_value("overflow flag", 1, int'(data[STATUS_OVF_BIT]));
        for (int i = 0; i < 8; i++) begin
            read_code(expected_q.pop_front(), "overflow");
        end
        wb_write(REG_STATUS, OVF_MASK);
        wb_read(REG_STATUS, data);
        check_value("overflow cleared", 0, int'(data));

        // the matrix sees no column drive while the scanner is off.
        wb_write(REG_CTRL, 32'h0);
        press_key(10);
        for (int i = 0; i < IDLE_CLKS; i++) begin
            @(negedge clk);
            check_value("disabled col", 'hF, int'(col));
        end
        release_key();
        wb_read(REG_STATUS, data);
        check_value("disabled status", 0, int'(data));

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: build.f
design/keypad_pkg.sv
design/keypad_scanner.sv
design/key_fifo.sv
design/keypad_regs.sv
design/keypad_ctrl_top.sv
sim/keypad_matrix_model.sv
sim/tb_keypad.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_keypad
FILELIST = build.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
